// File: pcs_pkg.sv
package pcs_pkg;

	// Word widths fixed by the 64b/66b coding
	localparam int NB_DATA_RAW   = 64;
	localparam int NB_CTRL_RAW   = 8;
	localparam int NB_DATA_CODED = 66;
	localparam int NB_SCR_STATE  = 58;

	// CGMII control characters
	localparam logic [7:0] CGMII_START     = 8'hFB;
	localparam logic [7:0] CGMII_TERMINATE = 8'hFD;
	localparam logic [7:0] CGMII_IDLE      = 8'h07;
	localparam logic [7:0] CGMII_ERROR     = 8'hFE;
	localparam logic [7:0] CGMII_Q         = 8'h9C;
	localparam logic [7:0] CGMII_FSIG      = 8'h5C;

	// PCS side characters and ordered set codes
	localparam logic [6:0] PCS_IDLE  = 7'h00;
	localparam logic [6:0] PCS_ERROR = 7'h1E;
	localparam logic [3:0] PCS_Q     = 4'h0;
	localparam logic [3:0] PCS_FSIG  = 4'hF;

	localparam logic [1:0] DATA_SH = 2'b01;
	localparam logic [1:0] CTRL_SH = 2'b10;

	// Block type field of control blocks
	localparam logic [7:0] BTYPE_CTRL  = 8'h1E;
	localparam logic [7:0] BTYPE_S     = 8'h78;
	localparam logic [7:0] BTYPE_ORDER = 8'h4B;
	localparam logic [7:0] BTYPE_T0    = 8'h87;
	localparam logic [7:0] BTYPE_T1    = 8'h99;
	localparam logic [7:0] BTYPE_T2    = 8'hAA;
	localparam logic [7:0] BTYPE_T3    = 8'hB4;
	localparam logic [7:0] BTYPE_T4    = 8'hCC;
	localparam logic [7:0] BTYPE_T5    = 8'hD2;
	localparam logic [7:0] BTYPE_T6    = 8'hE1;
	localparam logic [7:0] BTYPE_T7    = 8'hFF;

	// Block kind bits are data, start, control and terminate from the top
	// No bit set marks an unmatched word
	typedef logic [3:0] t_type_t;

	localparam t_type_t TT_DATA  = 4'b1000;
	localparam t_type_t TT_START = 4'b0100;
	localparam t_type_t TT_CTRL  = 4'b0010;
	localparam t_type_t TT_TERM  = 4'b0001;

	typedef struct packed {
		logic [1:0]             sh;
		logic [NB_DATA_RAW-1:0] payload;
	} pcs_data_view_t;

	typedef struct packed {
		logic [1:0]  sh;
		logic [7:0]  btype;
		logic [55:0] body;
	} pcs_ctrl_view_t;

	// One coded block seen either as payload or as type plus body
	typedef union packed {
		pcs_data_view_t data;
		pcs_ctrl_view_t ctrl;
	} pcs_block_t;

endpackage

// File: encoder_comparator.sv
`timescale 1ns/100ps

module encoder_comparator
	import pcs_pkg::*;
(
	input  logic                   i_clock,
	input  logic                   i_reset,
	input  logic                   i_valid,
	input  logic                   i_enable,
	input  logic [NB_DATA_RAW-1:0] i_tx_data,
	input  logic [NB_CTRL_RAW-1:0] i_tx_ctrl,
	output logic                   o_valid,
	output t_type_t                o_tx_type,
	output pcs_block_t             o_tx_coded
);

	// T0 at index 0 up to T7 at index 7
	localparam logic [7:0][7:0] TERM_BTYPE = {
		BTYPE_T7, BTYPE_T6, BTYPE_T5, BTYPE_T4,
		BTYPE_T3, BTYPE_T2, BTYPE_T1, BTYPE_T0
	};

	logic [NB_DATA_RAW-1:0] tx_data;
	logic [NB_CTRL_RAW-1:0] tx_ctrl;
	logic                   valid_reg;

	// Byte 0 is the top byte of the word and bit 7 of the control vector
	logic [7:0] cgmii_byte [0:7];
	logic [6:0] pcs_char [0:7];
	logic [7:0] valid_char;
	logic [7:0] term_hit;

	logic is_data;
	logic is_start;
	logic is_q;
	logic is_fsig;
	logic is_idle;

	// Idle and error map to PCS characters and anything else is flagged
	function automatic logic [7:0] map_char(input logic [7:0] char_in);
		logic [7:0] result;
		case (char_in)
			CGMII_IDLE:  result = {1'b1, PCS_IDLE};
			CGMII_ERROR: result = {1'b1, PCS_ERROR};
			default:     result = {1'b0, PCS_ERROR};
		endcase
		return result;
	endfunction

	always_ff @(posedge i_clock)
	begin
		if (i_reset)
			valid_reg <= 1'b0;
		else if (i_enable)
			valid_reg <= i_valid;
	end

	always_ff @(posedge i_clock)
	begin
		if (i_enable && i_valid)
		begin
			tx_data <= i_tx_data;
			tx_ctrl <= i_tx_ctrl;
		end
	end

	always_comb
	begin
		for (int i = 0; i < 8; i++)
		begin
			cgmii_byte[i] = tx_data[NB_DATA_RAW-1-8*i -: 8];
			{valid_char[7-i], pcs_char[i]} = map_char(cgmii_byte[i]);
		end
	end

	// Tk needs the terminate at byte k and only idle or error after it
	always_comb
	begin
		for (int k = 0; k < 8; k++)
		begin
			term_hit[k] = (tx_ctrl == (8'hFF >> k))
				&& (cgmii_byte[k] == CGMII_TERMINATE)
				&& ((valid_char & (8'hFF >> (k + 1))) == (8'hFF >> (k + 1)));
		end
	end

	assign is_data  = (tx_ctrl == 8'h00);
	assign is_start = (tx_ctrl == 8'h80) && (cgmii_byte[0] == CGMII_START);
	assign is_q     = (tx_ctrl == 8'h80) && (cgmii_byte[0] == CGMII_Q);
	assign is_fsig  = (tx_ctrl == 8'h80) && (cgmii_byte[0] == CGMII_FSIG);
	assign is_idle  = (tx_ctrl == 8'hFF) && (tx_data == {8{CGMII_IDLE}});

	always_comb
	begin
		// Unmatched words become a block of error characters
		o_tx_type             = '0;
		o_tx_coded.ctrl.sh    = CTRL_SH;
		o_tx_coded.ctrl.btype = BTYPE_CTRL;
		o_tx_coded.ctrl.body  = {8{PCS_ERROR}};

		if (is_data)
		begin
			o_tx_type               = TT_DATA;
			o_tx_coded.data.sh      = DATA_SH;
			o_tx_coded.data.payload = tx_data;
		end
		else if (is_start)
		begin
			o_tx_type             = TT_START;
			o_tx_coded.ctrl.btype = BTYPE_S;
			o_tx_coded.ctrl.body  = tx_data[55:0];
		end
		else if (is_q || is_fsig)
		begin
			o_tx_type             = TT_CTRL;
			o_tx_coded.ctrl.btype = BTYPE_ORDER;
			o_tx_coded.ctrl.body  = {tx_data[55 -: 24], (is_q ? PCS_Q : PCS_FSIG), 28'd0};
		end
		else if (is_idle)
		begin
			o_tx_type            = TT_CTRL;
			o_tx_coded.ctrl.body = {8{PCS_IDLE}};
		end
		else if (|term_hit)
		begin
			o_tx_type            = TT_TERM;
			o_tx_coded.ctrl.body = '0;
			for (int k = 0; k < 8; k++)
			begin
				if (term_hit[k])
				begin
					o_tx_coded.ctrl.btype = TERM_BTYPE[k];
					// Data bytes packed from the top and PCS characters from the bottom
					for (int j = 0; j < 8; j++)
					begin
						if (j < k)
							o_tx_coded.ctrl.body[55-8*j -: 8] = cgmii_byte[j];
						else if (j > k)
							o_tx_coded.ctrl.body[7*(7-j)+6 -: 7] = pcs_char[j];
					end
				end
			end
		end
	end

	assign o_valid = valid_reg;

endmodule

// File: tx_encode_fsm.sv
`timescale 1ns/100ps

module tx_encode_fsm
	import pcs_pkg::*;
(
	input  logic       i_clock,
	input  logic       i_reset,
	input  logic       i_enable,
	input  logic       i_valid,
	input  t_type_t    i_tx_type,
	input  pcs_block_t i_tx_coded,
	output logic       o_valid,
	output logic       o_block_error,
	output pcs_block_t o_tx_block
);

	localparam logic [1:0] ST_CTRL  = 2'd0;
	localparam logic [1:0] ST_DATA  = 2'd1;
	localparam logic [1:0] ST_TERM  = 2'd2;
	localparam logic [1:0] ST_ERROR = 2'd3;

	logic [1:0] state;
	logic [1:0] next_state;
	pcs_block_t error_block;

	// Terminate is judged against the previous block only
	always_comb
	begin
		next_state = ST_ERROR;
		case (state)
			ST_CTRL, ST_TERM:
			begin
				if (i_tx_type == TT_CTRL)
					next_state = ST_CTRL;
				else if (i_tx_type == TT_START)
					next_state = ST_DATA;
			end
			ST_DATA:
			begin
				if (i_tx_type == TT_DATA)
					next_state = ST_DATA;
				else if (i_tx_type == TT_TERM)
					next_state = ST_TERM;
			end
			default:
			begin
				case (i_tx_type)
					TT_DATA:  next_state = ST_DATA;
					TT_START: next_state = ST_DATA;
					TT_TERM:  next_state = ST_TERM;
					TT_CTRL:  next_state = ST_CTRL;
					default:  next_state = ST_ERROR;
				endcase
			end
		endcase
	end

	always_comb
	begin
		error_block.ctrl.sh    = CTRL_SH;
		error_block.ctrl.btype = BTYPE_CTRL;
		error_block.ctrl.body  = {8{PCS_ERROR}};
	end

	always_ff @(posedge i_clock)
	begin
		if (i_reset)
		begin
			state         <= ST_CTRL;
			o_valid       <= 1'b0;
			o_block_error <= 1'b0;
		end
		else if (i_enable)
		begin
			o_valid       <= i_valid;
			o_block_error <= i_valid && (next_state == ST_ERROR);
			if (i_valid)
				state <= next_state;
		end
	end

	always_ff @(posedge i_clock)
	begin
		if (i_enable && i_valid)
			o_tx_block <= (next_state == ST_ERROR) ? error_block : i_tx_coded;
	end

endmodule

// File: pcs_scrambler.sv
`timescale 1ns/100ps

module pcs_scrambler
	import pcs_pkg::*;
#(
	parameter logic [NB_SCR_STATE-1:0] SCRAMBLER_SEED = '1
)
(
	input  logic       i_clock,
	input  logic       i_reset,
	input  logic       i_enable,
	input  logic       i_valid,
	input  pcs_block_t i_block,
	input  logic       i_block_error,
	output logic       o_valid,
	output logic       o_block_error,
	output pcs_block_t o_block
);

	// Taps of x^58 + x^39 + 1
	localparam int TAP_39 = 38;
	localparam int TAP_58 = NB_SCR_STATE - 1;

	logic [NB_SCR_STATE-1:0] scr_state;
	logic [NB_SCR_STATE-1:0] scr_next;
	logic [NB_DATA_RAW-1:0]  scr_payload;

	// Bit 0 goes first and each output bit feeds back into the state
	always_comb
	begin
		scr_next = scr_state;
		for (int i = 0; i < NB_DATA_RAW; i++)
		begin
			scr_payload[i] = i_block.data.payload[i] ^ scr_next[TAP_39] ^ scr_next[TAP_58];
			scr_next       = {scr_next[NB_SCR_STATE-2:0], scr_payload[i]};
		end
	end

	always_ff @(posedge i_clock)
	begin
		if (i_reset)
		begin
			scr_state     <= SCRAMBLER_SEED;
			o_valid       <= 1'b0;
			o_block_error <= 1'b0;
		end
		else if (i_enable)
		begin
			o_valid       <= i_valid;
			o_block_error <= i_valid && i_block_error;
			if (i_valid)
				scr_state <= scr_next;
		end
	end

	// Sync header bypasses the scrambler
	always_ff @(posedge i_clock)
	begin
		if (i_enable && i_valid)
			o_block <= {i_block.data.sh, scr_payload};
	end

endmodule

// File: pcs_tx_top.sv
`timescale 1ns/100ps

module pcs_tx_top
	import pcs_pkg::*;
#(
	parameter logic [NB_SCR_STATE-1:0] SCRAMBLER_SEED = '1
)
(
	input  logic                   i_clock,
	input  logic                   i_reset,
	input  logic                   i_valid,
	input  logic                   i_enable,
	input  logic [NB_DATA_RAW-1:0] i_tx_data,
	input  logic [NB_CTRL_RAW-1:0] i_tx_ctrl,
	output logic                   o_valid,
	output logic                   o_block_error,
	output pcs_block_t             o_tx_block
);

	logic       enc_valid;
	t_type_t    enc_type;
	pcs_block_t enc_coded;

	logic       fsm_valid;
	logic       fsm_error;
	pcs_block_t fsm_block;

	// Classify and encode the CGMII word
	encoder_comparator u_encoder (
		.i_clock    (i_clock),
		.i_reset    (i_reset),
		.i_valid    (i_valid),
		.i_enable   (i_enable),
		.i_tx_data  (i_tx_data),
		.i_tx_ctrl  (i_tx_ctrl),
		.o_valid    (enc_valid),
		.o_tx_type  (enc_type),
		.o_tx_coded (enc_coded)
	);

	// Sequence check
	tx_encode_fsm u_fsm (
		.i_clock       (i_clock),
		.i_reset       (i_reset),
		.i_enable      (i_enable),
		.i_valid       (enc_valid),
		.i_tx_type     (enc_type),
		.i_tx_coded    (enc_coded),
		.o_valid       (fsm_valid),
		.o_block_error (fsm_error),
		.o_tx_block    (fsm_block)
	);

	pcs_scrambler #(
		.SCRAMBLER_SEED (SCRAMBLER_SEED)
	) u_scrambler (
		.i_clock       (i_clock),
		.i_reset       (i_reset),
		.i_enable      (i_enable),
		.i_valid       (fsm_valid),
		.i_block       (fsm_block),
		.i_block_error (fsm_error),
		.o_valid       (o_valid),
		.o_block_error (o_block_error),
		.o_block       (o_tx_block)
	);

endmodule

// File: pcs_tx_assert.sv
`timescale 1ns/100ps

module pcs_tx_assert
	import pcs_pkg::*;
(
	input logic       i_clock,
	input logic       i_reset,
	input logic       i_enable,
	input logic       i_out_valid,
	input logic       i_out_error,
	input pcs_block_t i_out_block
);

	// Synchronous reset shows on the outputs one edge later
	reset_clears: assert property (@(posedge i_clock)
		i_reset && $past(i_reset) |-> !i_out_valid && !i_out_error)
		else $error("output valid or block error high during reset");

	// An error block always leaves as a valid control block
	error_needs_valid: assert property (@(posedge i_clock) disable iff (i_reset)
		i_out_error |-> i_out_valid && (i_out_block.data.sh == CTRL_SH))
		else $error("block error flag raised without a valid control block");

	legal_sync_header: assert property (@(posedge i_clock) disable iff (i_reset)
		i_out_valid |-> (i_out_block.data.sh == DATA_SH) || (i_out_block.data.sh == CTRL_SH))
		else $error("valid block carries an illegal sync header");

	// A stalled cycle freezes every stage
	hold_on_stall: assert property (@(posedge i_clock) disable iff (i_reset)
		!$past(i_enable) && !$past(i_reset)
			|-> $stable(i_out_valid) && $stable(i_out_error) && $stable(i_out_block))
		else $error("outputs changed on a cycle with enable low");

endmodule

bind pcs_tx_top pcs_tx_assert u_assert (
	.i_clock     (i_clock),
	.i_reset     (i_reset),
	.i_enable    (i_enable),
	.i_out_valid (o_valid),
	.i_out_error (o_block_error),
	.i_out_block (o_tx_block)
);

// File: tb_clock_gen.sv
`timescale 1ns/100ps

module tb_clock_gen #(
	parameter int PERIOD_NS    = 100,
	parameter int RESET_CYCLES = 4
)
(
	output logic o_clock,
	output logic o_reset
);

	// Reset held high for the first rising edges
	initial
	begin
		o_clock = 1'b0;
		o_reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge o_clock);
		o_reset <= 1'b0;
	end

	always #(PERIOD_NS / 2) o_clock = ~o_clock;

endmodule

// File: tb_pcs_tx.sv
`timescale 1ns/100ps

module tb_pcs_tx
	import pcs_pkg::*;
();

	localparam string VECTOR_FILE  = "pcs_tx_vectors.txt";
	localparam int    RESET_CYCLES = 4;

	logic                   clock;
	logic                   reset;
	logic                   valid;
	logic                   enable;
	logic [NB_DATA_RAW-1:0] tx_data;
	logic [NB_CTRL_RAW-1:0] tx_ctrl;
	logic                   out_valid;
	logic                   block_error;
	pcs_block_t             tx_block;

	// Words to drive are built before the run starts
	string                  word_name [$];
	logic [NB_CTRL_RAW-1:0] word_ctrl [$];
	logic [NB_DATA_RAW-1:0] word_data [$];
	pcs_block_t             word_block [$];
	logic                   word_flag [$];
	int                     word_stall [$];
	int                     total_stalls;

	// Unscrambled blocks still expected on the output
	string      exp_name [$];
	pcs_block_t exp_block [$];
	logic       exp_flag [$];

	logic [31:0]             lcg_state;
	logic [NB_SCR_STATE-1:0] scr_model;
	int                      cycle_count;
	int                      cycle_limit;

	tb_clock_gen #(
		.PERIOD_NS    (100),
		.RESET_CYCLES (RESET_CYCLES)
	) u_clock_gen (
		.o_clock (clock),
		.o_reset (reset)
	);

	pcs_tx_top dut (
		.i_clock       (clock),
		.i_reset       (reset),
		.i_valid       (valid),
		.i_enable      (enable),
		.i_tx_data     (tx_data),
		.i_tx_ctrl     (tx_ctrl),
		.o_valid       (out_valid),
		.o_block_error (block_error),
		.o_tx_block    (tx_block)
	);

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state;
	endfunction

	// x^58 + x^39 + 1 over the payload from bit 0 up and the sync header untouched
	function automatic pcs_block_t scramble_block(input pcs_block_t plain);
		pcs_block_t result;
		logic       out_bit;
		result = plain;
		for (int i = 0; i < NB_DATA_RAW; i++)
		begin
			out_bit = plain.data.payload[i] ^ scr_model[38] ^ scr_model[57];
			result.data.payload[i] = out_bit;
			scr_model = {scr_model[NB_SCR_STATE-2:0], out_bit};
		end
		return result;
	endfunction

	function automatic string trim_name(input logic [8*32-1:0] bits);
		string text;
		int    first;
		text  = $sformatf("%0s", bits);
		first = 0;
		while (first < text.len() && (text.getc(first) == 8'h20 || text.getc(first) == 8'h00))
			first++;
		return text.substr(first, text.len() - 1);
	endfunction

	task automatic stop_with_failure();
		$display("** FAIL **");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic compare_block(input string name, input pcs_block_t expected,
		input pcs_block_t actual);
		if (actual !== expected)
		begin
			$display("mismatch %0s: expected block %h, actual block %h", name, expected, actual);
			stop_with_failure();
		end
	endtask

	task automatic compare_flag(input string name, input logic expected, input logic actual);
		if (actual !== expected)
		begin
			$display("mismatch %0s: expected error flag %b, actual error flag %b",
				name, expected, actual);
			stop_with_failure();
		end
	endtask

	// About one word in four waits behind one to four stall cycles
	task automatic add_word(input string name, input logic [NB_CTRL_RAW-1:0] ctrl,
		input logic [NB_DATA_RAW-1:0] data, input pcs_block_t block, input logic flag);
		logic [31:0] rnd;
		int          stall;
		rnd   = lcg_next();
		stall = (rnd[31:30] == 2'b00) ? int'(rnd[17:16]) + 1 : 0;
		word_name.push_back(name);
		word_ctrl.push_back(ctrl);
		word_data.push_back(data);
		word_block.push_back(block);
		word_flag.push_back(flag);
		word_stall.push_back(stall);
		total_stalls += stall;
	endtask

	task automatic load_vectors();
		int                       fd;
		int                       fields;
		int                       gap;
		string                    line;
		logic [8*32-1:0]          name_bits;
		logic [NB_CTRL_RAW-1:0]   ctrl;
		logic [NB_DATA_RAW-1:0]   data;
		logic [NB_DATA_RAW-1:0]   rnd_data;
		logic [NB_DATA_CODED-1:0] block_bits;
		pcs_block_t               block;
		logic                     flag;
		fd = $fopen(VECTOR_FILE, "r");
		if (fd == 0)
		begin
			$display("cannot open the vector file %0s", VECTOR_FILE);
			stop_with_failure();
		end
		while (!$feof(fd))
		begin
			line = "";
			void'($fgets(line, fd));
			if (line.len() > 0 && line.getc(0) != "#")
			begin
				fields = $sscanf(line, "%s %h %h %h %b", name_bits, ctrl, data, block_bits, flag);
				if (fields == 5)
				begin
					block = block_bits;
					add_word(trim_name(name_bits), ctrl, data, block, flag);
					// Random data words are legal only inside a frame
					if (!flag && (block.data.sh == DATA_SH || block.ctrl.btype == BTYPE_S))
					begin
						gap = int'(lcg_next() >> 30);
						for (int g = 0; g < gap; g++)
						begin
							rnd_data[63:32] = lcg_next();
							rnd_data[31:0]  = lcg_next();
							add_word("random_data", 8'h00, rnd_data, {DATA_SH, rnd_data}, 1'b0);
						end
					end
				end
				else if (fields > 0)
				begin
					$display("malformed line in the vector file: %0s", line);
					stop_with_failure();
				end
			end
		end
		$fclose(fd);
	endtask

	always @(posedge clock)
		cycle_count <= cycle_count + 1;

	// Outputs are stable at the falling edge and enable says whether the block leaves next
	always @(negedge clock)
	begin : check_outputs
		string      name;
		pcs_block_t expected;
		logic       flag;
		if (reset === 1'b0 && out_valid === 1'b1 && enable === 1'b1)
		begin
			if (exp_block.size() == 0)
			begin
				$display("a block came out while no word was pending");
				stop_with_failure();
			end
			else
			begin
				name     = exp_name.pop_front();
				expected = scramble_block(exp_block.pop_front());
				flag     = exp_flag.pop_front();
				compare_block(name, expected, tx_block);
				compare_flag(name, flag, block_error);
			end
		end
	end

	initial
	begin : run_test
		valid        = 1'b0;
		enable       = 1'b0;
		tx_data      = '0;
		tx_ctrl      = '0;
		cycle_count  = 0;
		total_stalls = 0;
		lcg_state    = 32'd87;
		scr_model    = '1;
		load_vectors();
		cycle_limit = RESET_CYCLES + 2 * (word_data.size() + total_stalls) + 20;

		@(negedge reset);
		for (int w = 0; w < word_data.size(); w++)
		begin
			// Word held on the bus while the pipeline is stalled
			for (int s = 0; s < word_stall[w]; s++)
			begin
				@(posedge clock);
				enable  <= 1'b0;
				valid   <= 1'b1;
				tx_data <= word_data[w];
				tx_ctrl <= word_ctrl[w];
			end
			@(posedge clock);
			enable  <= 1'b1;
			valid   <= 1'b1;
			tx_data <= word_data[w];
			tx_ctrl <= word_ctrl[w];
			exp_name.push_back(word_name[w]);
			exp_block.push_back(word_block[w]);
			exp_flag.push_back(word_flag[w]);
		end
		@(posedge clock);
		valid  <= 1'b0;
		enable <= 1'b1;

		while (exp_block.size() > 0 && cycle_count < cycle_limit)
			@(posedge clock);
		repeat (4) @(posedge clock);

		if (exp_block.size() == 0)
		begin
			$display("** PASS **");
			$finish;
		end
		else
		begin
			$display("outputs stopped arriving: %0d blocks missing after %0d cycles",
				exp_block.size(), cycle_count);
			stop_with_failure();
		end
	end

endmodule

// File: pcs_tx_vectors.txt
# name  ctrl  data  expected_unscrambled_block  error_flag
# blocks are 66-bit hex, sync header in the top two bits
idle_a           ff 0707070707070707 21E00000000000000 0
order_q          80 9c12345600000000 24B12345600000000 0
order_fsig       80 5cabcdef00000000 24BABCDEFF0000000 0
data_after_idle  00 deadbeef01234567 21E3C78F1E3C78F1E 1
idle_b           ff 0707070707070707 21E00000000000000 0
start_a          80 fb555555555555d5 278555555555555D5 0
data_a           00 0011223344556677 10011223344556677 0
start_in_frame   80 fb555555555555d5 21E3C78F1E3C78F1E 1
data_b           00 8899aabbccddeeff 18899AABBCCDDEEFF 0
term_t0          ff fd070707070707fe 2870000000000001E 0
term_after_term  0f 31323334fd070707 21E3C78F1E3C78F1E 1
start_b          80 fb555555555555d5 278555555555555D5 0
term_t1          7f 11fd0707070707fe 2991100000000001E 0
start_c          80 fb555555555555d5 278555555555555D5 0
term_t2          3f 2122fdfe07070707 2AA212201E0000000 0
idle_c           ff 0707070707070707 21E00000000000000 0
start_d          80 fb555555555555d5 278555555555555D5 0
term_t3          1f aabbccfd07fe0707 2B4AABBCC00078000 0
start_e          80 fb555555555555d5 278555555555555D5 0
term_t4          0f 31323334fd070707 2CC31323334000000 0
start_f          80 fb555555555555d5 278555555555555D5 0
term_t5          07 4142434445fd07fe 2D24142434445001E 0
start_g          80 fb555555555555d5 278555555555555D5 0
term_t6          03 515253545556fd07 2E151525354555600 0
start_h          80 fb555555555555d5 278555555555555D5 0
term_bad_char    7f 11fd075507070707 21E3C78F1E3C78F1E 1
start_i          80 fb555555555555d5 278555555555555D5 0
term_t7          01 01020304050607fd 2FF01020304050607 0
idle_d           ff 0707070707070707 21E00000000000000 0

// File: project.f
pcs_pkg.sv
encoder_comparator.sv
tx_encode_fsm.sv
pcs_scrambler.sv
pcs_tx_top.sv
pcs_tx_assert.sv
tb_clock_gen.sv
tb_pcs_tx.sv

// File: run_sim.sh
#!/bin/sh
# Build with Verilator, run from the project root, decide on the log
cd "$(dirname "$0")" \
	&& verilator --binary --timing --assert -Wno-fatal --top-module tb_pcs_tx \
		-f project.f -o sim_pcs_tx \
	&& ./obj_dir/sim_pcs_tx | tee sim.log \
	&& grep -q "\*\* PASS \*\*" sim.log \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }
